/* hdl/iosys_bus_pkg.sv */
/*
  Register bus definitions for the IO peripheral block.
  The register window starts at REG_BASE; offsets below are relative to it.
  Only full-address matches select a register, all other addresses map to REG_NONE.
*/
package iosys_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam logic [ADDR_W-1:0] REG_BASE = 32'h0200_0000;

    // Register offsets from REG_BASE
    localparam logic [ADDR_W-1:0] OFS_ROM_CTRL     = 32'h030;
    localparam logic [ADDR_W-1:0] OFS_ROM_DATA     = 32'h034;
    localparam logic [ADDR_W-1:0] OFS_TIME_MS      = 32'h050;
    localparam logic [ADDR_W-1:0] OFS_CYCLES       = 32'h054;
    localparam logic [ADDR_W-1:0] OFS_ENH_APU      = 32'h080;
    localparam logic [ADDR_W-1:0] OFS_CHEAT_EN     = 32'h0A0;
    localparam logic [ADDR_W-1:0] OFS_CHEAT_LOADED = 32'h0C0;
    localparam logic [ADDR_W-1:0] OFS_CHEAT_W3     = 32'h0E0;
    localparam logic [ADDR_W-1:0] OFS_CHEAT_W2     = 32'h100;
    localparam logic [ADDR_W-1:0] OFS_CHEAT_W1     = 32'h120;
    localparam logic [ADDR_W-1:0] OFS_CHEAT_W0     = 32'h140;
    localparam logic [ADDR_W-1:0] OFS_CHEAT_READY  = 32'h160;
    localparam logic [ADDR_W-1:0] OFS_SAVE_BSRAM   = 32'h180;
    localparam logic [ADDR_W-1:0] OFS_LOAD_BSRAM   = 32'h1A0;
    localparam logic [ADDR_W-1:0] OFS_SYS_TYPE     = 32'h1C0;
    localparam logic [ADDR_W-1:0] OFS_ASPECT       = 32'h1E0;

    typedef enum logic [4:0] {
        REG_NONE, REG_ROM_CTRL, REG_ROM_DATA, REG_TIME_MS, REG_CYCLES,
        REG_ENH_APU, REG_CHEAT_EN, REG_CHEAT_LOADED,
        REG_CHEAT_W3, REG_CHEAT_W2, REG_CHEAT_W1, REG_CHEAT_W0,
        REG_CHEAT_READY, REG_SAVE_BSRAM, REG_LOAD_BSRAM, REG_SYS_TYPE, REG_ASPECT
    } reg_id_e;

    // Raw request from the bus master, 69 bits
    typedef struct packed {
        logic                  valid;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_W-1:0]     wdata;
        logic [DATA_W/8-1:0]   wstrb;
    } bus_req_t;

    // Decoded request, valid is a one-cycle pulse
    typedef struct packed {
        logic                  valid;
        reg_id_e               id;
        logic                  write;
        logic [DATA_W-1:0]     wdata;
        logic [DATA_W/8-1:0]   wstrb;
    } dec_req_t;

endpackage

/* hdl/iosys_cfg_pkg.sv */
/*
  Console configuration, cheat upload and ROM streaming definitions.
  ROM bytes use a fixed slot of ROM_BYTE_CYCLES valid plus ROM_GAP_CYCLES idle.
  The cheat block is uploaded as a single 128-bit Wishbone beat.
*/
package iosys_cfg_pkg;

    localparam int CHEAT_W = 128;
    localparam logic [1:0] WB_CHEAT_ADDR = 2'd1;

    localparam int ROM_BYTE_CYCLES = 2;
    localparam int ROM_GAP_CYCLES  = 2;

    typedef enum logic [1:0] {
        NTSC,
        PAL,
        DENDY
    } sys_type_e;

    // Configuration outputs, 8 bits
    typedef struct packed {
        logic       enhanced_apu;
        logic       cheats_enabled;
        logic       cheats_loaded;
        logic       save_bsram;
        logic       load_bsram;
        sys_type_e  sys_type;
        logic       aspect;
    } cfg_t;

    typedef struct packed {
        logic               enabled;
        logic               pending;
        logic [CHEAT_W-1:0] data;
    } cheat_req_t;

    // load pulses for one cycle per written word
    typedef struct packed {
        logic        load;
        logic [31:0] word;
    } rom_word_t;

    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [1:0]         addr;
        logic [CHEAT_W-1:0] data;
        logic [3:0]         sel;
    } wb_out_t;

endpackage

/* hdl/reg_decode.sv */
/*
  Registers one bus request and maps its address to a register ID.
  A busy flag blocks a held valid from issuing again; it clears on the
  response pulse from the register bank.
  A write needs at least one byte strobe set.
*/
`timescale 1ns/1ps

module reg_decode (
    input  logic                    clk,
    input  logic                    resetn,
    input  iosys_bus_pkg::bus_req_t i_req,
    input  logic                    i_resp_done,
    output iosys_bus_pkg::dec_req_t o_dec
);
    import iosys_bus_pkg::*;

    logic [ADDR_W-1:0] offset;
    reg_id_e           id_d;
    logic              busy;
    logic              accept;

    assign accept = i_req.valid && !busy;
    assign offset = i_req.addr - REG_BASE;

    always_comb begin
        case (offset)
            OFS_ROM_CTRL:     id_d = REG_ROM_CTRL;
            OFS_ROM_DATA:     id_d = REG_ROM_DATA;
            OFS_TIME_MS:      id_d = REG_TIME_MS;
            OFS_CYCLES:       id_d = REG_CYCLES;
            OFS_ENH_APU:      id_d = REG_ENH_APU;
            OFS_CHEAT_EN:     id_d = REG_CHEAT_EN;
            OFS_CHEAT_LOADED: id_d = REG_CHEAT_LOADED;
            OFS_CHEAT_W3:     id_d = REG_CHEAT_W3;
            OFS_CHEAT_W2:     id_d = REG_CHEAT_W2;
            OFS_CHEAT_W1:     id_d = REG_CHEAT_W1;
            OFS_CHEAT_W0:     id_d = REG_CHEAT_W0;
            OFS_CHEAT_READY:  id_d = REG_CHEAT_READY;
            OFS_SAVE_BSRAM:   id_d = REG_SAVE_BSRAM;
            OFS_LOAD_BSRAM:   id_d = REG_LOAD_BSRAM;
            OFS_SYS_TYPE:     id_d = REG_SYS_TYPE;
            OFS_ASPECT:       id_d = REG_ASPECT;
            default:          id_d = REG_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy  <= 1'b0;
            o_dec <= '0;
        end else begin
            o_dec.valid <= accept;
            if (accept) begin
                busy        <= 1'b1;
                o_dec.id    <= id_d;
                o_dec.write <= |i_req.wstrb;
                o_dec.wdata <= i_req.wdata;
                o_dec.wstrb <= i_req.wstrb;
            end else if (i_resp_done) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

/* hdl/reg_bank.sv */
/*
  Configuration registers, millisecond timer, cycle counter and readback.
  Every decoded request gets a one-cycle ready pulse, REG_NONE included.
  Reads return the value held before a write in the same request.
  Cheat words take byte strobes; W3 is the most significant word.
*/
`timescale 1ns/1ps

module reg_bank #(
    parameter int TICKS_PER_MS = 21477
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  iosys_bus_pkg::dec_req_t          i_dec,
    input  logic                             i_cheat_done,
    output logic                             o_resp_done,
    output logic                             o_mem_ready,
    output logic [iosys_bus_pkg::DATA_W-1:0] o_mem_rdata,
    output iosys_cfg_pkg::cfg_t              o_cfg,
    output logic                             o_rom_loading,
    output iosys_cfg_pkg::rom_word_t         o_rom_word,
    output iosys_cfg_pkg::cheat_req_t        o_cheat
);
    import iosys_bus_pkg::*;
    import iosys_cfg_pkg::*;

    localparam int TICK_W = (TICKS_PER_MS > 1) ? $clog2(TICKS_PER_MS) : 1;

    logic [CHEAT_W-1:0] cheat_q;
    logic               pending_q;
    logic [TICK_W-1:0]  tick_cnt;
    logic [DATA_W-1:0]  time_ms;
    logic [DATA_W-1:0]  cycles;
    logic               wr_en;
    logic [DATA_W-1:0]  rd_data;

    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0]   old_val,
        input logic [DATA_W-1:0]   new_val,
        input logic [DATA_W/8-1:0] strb
    );
        logic [DATA_W-1:0] res;
        res = old_val;
        for (int b = 0; b < DATA_W / 8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign wr_en       = i_dec.valid && i_dec.write;
    assign o_resp_done = o_mem_ready;
    assign o_cheat     = '{enabled: o_cfg.cheats_enabled, pending: pending_q, data: cheat_q};

    // Free-running counters
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tick_cnt <= '0;
            time_ms  <= '0;
            cycles   <= '0;
        end else begin
            cycles <= cycles + 1'b1;
            if (tick_cnt == TICK_W'(TICKS_PER_MS - 1)) begin
                tick_cnt <= '0;
                time_ms  <= time_ms + 1'b1;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // Control registers and response pulse
    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_cfg         <= '0;
            o_rom_loading <= 1'b0;
            o_rom_word    <= '0;
            o_mem_ready   <= 1'b0;
            pending_q     <= 1'b0;
        end else begin
            o_mem_ready     <= i_dec.valid;
            o_rom_word.load <= wr_en && (i_dec.id == REG_ROM_DATA);
            if (i_cheat_done) begin
                pending_q <= 1'b0;
            end
            if (wr_en) begin
                case (i_dec.id)
                    REG_ROM_CTRL: begin
                        if (i_dec.wdata == 32'd1) begin
                            o_rom_loading <= 1'b1;
                        end else if (i_dec.wdata == 32'd0) begin
                            o_rom_loading <= 1'b0;
                        end
                    end
                    REG_ROM_DATA:     o_rom_word.word      <= i_dec.wdata;
                    REG_ENH_APU:      o_cfg.enhanced_apu   <= i_dec.wdata[0];
                    REG_CHEAT_EN:     o_cfg.cheats_enabled <= i_dec.wdata[0];
                    REG_CHEAT_LOADED: o_cfg.cheats_loaded  <= i_dec.wdata[0];
                    REG_CHEAT_READY:  pending_q            <= i_dec.wdata[0];
                    REG_SAVE_BSRAM:   o_cfg.save_bsram     <= i_dec.wdata[0];
                    REG_LOAD_BSRAM:   o_cfg.load_bsram     <= i_dec.wdata[0];
                    REG_SYS_TYPE:     o_cfg.sys_type       <= sys_type_e'(i_dec.wdata[1:0]);
                    REG_ASPECT:       o_cfg.aspect         <= i_dec.wdata[0];
                    default: ;
                endcase
            end
        end
    end

    // Cheat block payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (i_dec.id)
                REG_CHEAT_W3: cheat_q[127:96] <= merge_bytes(cheat_q[127:96], i_dec.wdata,
                                                             i_dec.wstrb);
                REG_CHEAT_W2: cheat_q[95:64]  <= merge_bytes(cheat_q[95:64], i_dec.wdata,
                                                             i_dec.wstrb);
                REG_CHEAT_W1: cheat_q[63:32]  <= merge_bytes(cheat_q[63:32], i_dec.wdata,
                                                             i_dec.wstrb);
                REG_CHEAT_W0: cheat_q[31:0]   <= merge_bytes(cheat_q[31:0], i_dec.wdata,
                                                             i_dec.wstrb);
                default: ;
            endcase
        end
    end

    always_comb begin
        case (i_dec.id)
            REG_TIME_MS:      rd_data = time_ms;
            REG_CYCLES:       rd_data = cycles;
            REG_ENH_APU:      rd_data = {31'd0, o_cfg.enhanced_apu};
            REG_CHEAT_EN:     rd_data = {31'd0, o_cfg.cheats_enabled};
            REG_CHEAT_LOADED: rd_data = {31'd0, o_cfg.cheats_loaded};
            REG_CHEAT_W3:     rd_data = cheat_q[127:96];
            REG_CHEAT_W2:     rd_data = cheat_q[95:64];
            REG_CHEAT_W1:     rd_data = cheat_q[63:32];
            REG_CHEAT_W0:     rd_data = cheat_q[31:0];
            REG_CHEAT_READY:  rd_data = {31'd0, pending_q};
            REG_SAVE_BSRAM:   rd_data = {31'd0, o_cfg.save_bsram};
            REG_LOAD_BSRAM:   rd_data = {31'd0, o_cfg.load_bsram};
            REG_SYS_TYPE:     rd_data = {30'd0, o_cfg.sys_type};
            REG_ASPECT:       rd_data = {31'd0, o_cfg.aspect};
            // ROM registers are write-only
            default:          rd_data = '0;
        endcase
    end

    // Readback is only meaningful while o_mem_ready is high
    always_ff @(posedge clk) begin
        o_mem_rdata <= rd_data;
    end

endmodule

/* hdl/rom_byte_streamer.sv */
/*
  Serializes a 32-bit ROM word into four bytes, least significant first.
  Each byte is valid for ROM_BYTE_CYCLES, then idle for ROM_GAP_CYCLES.
  A new load restarts the sequence with the new word.
*/
`timescale 1ns/1ps

module rom_byte_streamer (
    input  logic                     clk,
    input  logic                     resetn,
    input  iosys_cfg_pkg::rom_word_t i_rom_word,
    output logic [7:0]               o_rom_do,
    output logic                     o_rom_do_valid
);
    import iosys_cfg_pkg::*;

    localparam int SLOT    = ROM_BYTE_CYCLES + ROM_GAP_CYCLES;
    localparam int PHASE_W = (SLOT > 1) ? $clog2(SLOT) : 1;

    logic [31:0]        shreg;
    logic [PHASE_W-1:0] phase;
    logic [1:0]         byte_idx;
    logic               active;

    assign o_rom_do       = shreg[7:0];
    assign o_rom_do_valid = active && (phase < PHASE_W'(ROM_BYTE_CYCLES));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            active   <= 1'b0;
            phase    <= '0;
            byte_idx <= '0;
        end else if (i_rom_word.load) begin
            active   <= 1'b1;
            phase    <= '0;
            byte_idx <= '0;
        end else if (active) begin
            if (phase == PHASE_W'(SLOT - 1)) begin
                phase <= '0;
                // Last gap done
                if (byte_idx == 2'd3) begin
                    active <= 1'b0;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rom_word.load) begin
            shreg <= i_rom_word.word;
        end else if (active && phase == PHASE_W'(SLOT - 1)) begin
            shreg <= {8'd0, shreg[31:8]};
        end
    end

endmodule

/* hdl/cheat_wb_master.sv */
/*
  Single-beat Wishbone write of the 128-bit cheat block.
  A cycle starts when the block is enabled and pending, stall is low and
  no cycle is open. stb and we last one cycle; cyc waits for ack or err.
  o_done pulses in the first cycle after cyc falls and holds off a restart
  until the register bank has cleared pending.
*/
`timescale 1ns/1ps

module cheat_wb_master (
    input  logic                      clk,
    input  logic                      resetn,
    input  iosys_cfg_pkg::cheat_req_t i_cheat,
    input  logic                      i_wb_ack,
    input  logic                      i_wb_stall,
    input  logic                      i_wb_err,
    output iosys_cfg_pkg::wb_out_t    o_wb,
    output logic                      o_done
);
    import iosys_cfg_pkg::*;

    logic start;

    assign start = i_cheat.enabled && i_cheat.pending && !i_wb_stall
                   && !o_wb.cyc && !o_done;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_wb   <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (start) begin
                o_wb.cyc  <= 1'b1;
                o_wb.stb  <= 1'b1;
                o_wb.we   <= 1'b1;
                o_wb.addr <= WB_CHEAT_ADDR;
                o_wb.data <= i_cheat.data;
                o_wb.sel  <= '1;
            end else if (o_wb.cyc) begin
                // Single strobe, then wait for the slave
                o_wb.stb <= 1'b0;
                o_wb.we  <= 1'b0;
                if (i_wb_ack || i_wb_err) begin
                    o_wb.cyc <= 1'b0;
                    o_done   <= 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/iosys_periph.sv */
/*
  IO peripheral top: register decode, register bank, ROM byte
  streamer and Wishbone cheat uploader.
  The bus master keeps one request in flight and holds valid until it
  sees o_mem_ready; ready follows the first sampled valid by 2 cycles.
  TICKS_PER_MS is the number of clk cycles per millisecond.
*/
`timescale 1ns/1ps

module iosys_periph #(
    parameter int TICKS_PER_MS = 21477
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  iosys_bus_pkg::bus_req_t          i_req,
    output logic                             o_mem_ready,
    output logic [iosys_bus_pkg::DATA_W-1:0] o_mem_rdata,
    output iosys_cfg_pkg::cfg_t              o_cfg,
    output logic                             o_rom_loading,
    output logic [7:0]                       o_rom_do,
    output logic                             o_rom_do_valid,
    output iosys_cfg_pkg::wb_out_t           o_wb,
    input  logic                             i_wb_ack,
    input  logic                             i_wb_stall,
    input  logic                             i_wb_err
);
    import iosys_bus_pkg::*;
    import iosys_cfg_pkg::*;

    dec_req_t   dec;
    logic       resp_done;
    rom_word_t  rom_word;
    cheat_req_t cheat;
    logic       cheat_done;

    reg_decode u_decode (
        .clk         (clk),
        .resetn      (resetn),
        .i_req       (i_req),
        .i_resp_done (resp_done),
        .o_dec       (dec)
    );

    reg_bank #(
        .TICKS_PER_MS (TICKS_PER_MS)
    ) u_bank (
        .clk           (clk),
        .resetn        (resetn),
        .i_dec         (dec),
        .i_cheat_done  (cheat_done),
        .o_resp_done   (resp_done),
        .o_mem_ready   (o_mem_ready),
        .o_mem_rdata   (o_mem_rdata),
        .o_cfg         (o_cfg),
        .o_rom_loading (o_rom_loading),
        .o_rom_word    (rom_word),
        .o_cheat       (cheat)
    );

    rom_byte_streamer u_rom (
        .clk            (clk),
        .resetn         (resetn),
        .i_rom_word     (rom_word),
        .o_rom_do       (o_rom_do),
        .o_rom_do_valid (o_rom_do_valid)
    );

    cheat_wb_master u_cheat_wb (
        .clk        (clk),
        .resetn     (resetn),
        .i_cheat    (cheat),
        .i_wb_ack   (i_wb_ack),
        .i_wb_stall (i_wb_stall),
        .i_wb_err   (i_wb_err),
        .o_wb       (o_wb),
        .o_done     (cheat_done)
    );

endmodule

/* verif/iosys_periph_assertions.sv */
/*
  Bus and Wishbone protocol checks, bound into iosys_periph.
  All checks are disabled while resetn is low.
*/
`timescale 1ns/1ps

module iosys_periph_assertions (
    input logic                   clk,
    input logic                   resetn,
    input iosys_bus_pkg::bus_req_t i_req,
    input logic                   o_mem_ready,
    input iosys_cfg_pkg::wb_out_t o_wb
);

    ready_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        o_mem_ready |=> !o_mem_ready)
        else $error("o_mem_ready high for two cycles in a row");

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!resetn)
        o_wb.stb |-> o_wb.cyc)
        else $error("Wishbone stb high without cyc");

    stb_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        o_wb.stb |=> !o_wb.stb)
        else $error("Wishbone stb longer than one cycle");

    // Two cycles from the first sampled valid to ready
    ready_latency: assert property (@(posedge clk) disable iff (!resetn)
        $rose(i_req.valid) |-> ##2 o_mem_ready)
        else $error("o_mem_ready did not follow valid by 2 cycles");

endmodule

bind iosys_periph iosys_periph_assertions assertions_i (
    .clk         (clk),
    .resetn      (resetn),
    .i_req       (i_req),
    .o_mem_ready (o_mem_ready),
    .o_wb        (o_wb)
);

/* include/iosys_periph_tb_tasks.svh */
/*
  Bus tasks, register model and compare tasks for the IO peripheral testbench.
  Included inside the testbench module, after the package imports.
  Every access holds valid until ready, drops it and then idles one cycle.
*/
`ifndef IOSYS_PERIPH_TB_TASKS_SVH
`define IOSYS_PERIPH_TB_TASKS_SVH

task automatic compare_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        abort_run("data word mismatch");
    end
endtask

task automatic compare_cfg(input string name, input cfg_t got, input cfg_t exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        abort_run("configuration output mismatch");
    end
endtask

task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        abort_run("ROM byte mismatch");
    end
endtask

task automatic compare_wb(input string name, input wb_out_t got, input wb_out_t exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        abort_run("Wishbone beat mismatch");
    end
endtask

task automatic check_that(input logic cond, input string what);
    if (!cond) begin
        $display("Check failed at t=%0t: %s", $time, what);
        abort_run(what);
    end
endtask

task automatic wait_cycles(input int n);
    repeat (n) begin
        @(posedge clk);
        #1;
    end
endtask

// Expected readback from the shadow registers
function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
    case (addr - REG_BASE)
        OFS_ENH_APU:      return {31'd0, shadow_cfg.enhanced_apu};
        OFS_CHEAT_EN:     return {31'd0, shadow_cfg.cheats_enabled};
        OFS_CHEAT_LOADED: return {31'd0, shadow_cfg.cheats_loaded};
        OFS_CHEAT_W3:     return shadow_cheat[127:96];
        OFS_CHEAT_W2:     return shadow_cheat[95:64];
        OFS_CHEAT_W1:     return shadow_cheat[63:32];
        OFS_CHEAT_W0:     return shadow_cheat[31:0];
        OFS_CHEAT_READY:  return {31'd0, shadow_ready};
        OFS_SAVE_BSRAM:   return {31'd0, shadow_cfg.save_bsram};
        OFS_LOAD_BSRAM:   return {31'd0, shadow_cfg.load_bsram};
        OFS_SYS_TYPE:     return {30'd0, shadow_cfg.sys_type};
        OFS_ASPECT:       return {31'd0, shadow_cfg.aspect};
        default:          return '0;
    endcase
endfunction

function automatic void apply_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] d);
    case (addr - REG_BASE)
        OFS_ROM_CTRL: begin
            if (d == 32'd1) begin
                shadow_loading = 1'b1;
            end else if (d == 32'd0) begin
                shadow_loading = 1'b0;
            end
        end
        OFS_ENH_APU:      shadow_cfg.enhanced_apu = d[0];
        OFS_CHEAT_EN:     shadow_cfg.cheats_enabled = d[0];
        OFS_CHEAT_LOADED: shadow_cfg.cheats_loaded = d[0];
        OFS_CHEAT_W3:     shadow_cheat[127:96] = d;
        OFS_CHEAT_W2:     shadow_cheat[95:64] = d;
        OFS_CHEAT_W1:     shadow_cheat[63:32] = d;
        OFS_CHEAT_W0:     shadow_cheat[31:0] = d;
        OFS_CHEAT_READY:  shadow_ready = d[0];
        OFS_SAVE_BSRAM:   shadow_cfg.save_bsram = d[0];
        OFS_LOAD_BSRAM:   shadow_cfg.load_bsram = d[0];
        OFS_SYS_TYPE:     shadow_cfg.sys_type = sys_type_e'(d[1:0]);
        OFS_ASPECT:       shadow_cfg.aspect = d[0];
        default: ;
    endcase
endfunction

task automatic bus_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                          input logic [DATA_W/8-1:0] wstrb, output logic [DATA_W-1:0] rdata);
    int waited;
    waited = 0;
    last_issue = cycle_cnt;
    req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    do begin
        @(posedge clk);
        #1;
        waited++;
    end while (!mem_ready);
    compare_word("o_mem_ready latency", 32'(waited), 32'd2);
    rdata = mem_rdata;
    @(posedge clk);
    #1;
    req.valid = 1'b0;
    compare_word("o_mem_ready second pulse", {31'd0, mem_ready}, 32'd0);
    wait_cycles(1);
    // A held valid must not issue a second request
    compare_word("o_mem_ready repeat pulse", {31'd0, mem_ready}, 32'd0);
endtask

task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] unused_rdata;
    bus_access(addr, wdata, 4'hF, unused_rdata);
    apply_write(addr, wdata);
endtask

// Random wdata with no strobes must not change anything
task automatic read_check(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] rdata;
    bus_access(addr, $urandom(), 4'h0, rdata);
    compare_word($sformatf("o_mem_rdata @%h", addr), rdata, expected_read(addr));
endtask

`endif

/* verif/iosys_periph_tb.sv */
/*
  Testbench for iosys_periph, built with TICKS_PER_MS = 10.
  Inputs change 1 ns after the rising edge; the Wishbone monitor samples
  on the falling edge. The slave acks after a random delay, never stalls
  and never signals an error.
*/
`timescale 1ns/1ps

module iosys_periph_tb;
    import iosys_bus_pkg::*;
    import iosys_cfg_pkg::*;

    // All tests need well under 1000 cycles
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int ROM_SLOT = ROM_BYTE_CYCLES + ROM_GAP_CYCLES;
    localparam logic [ADDR_W-1:0] RW_OFS [12] = '{
        OFS_ENH_APU, OFS_CHEAT_EN, OFS_CHEAT_LOADED, OFS_CHEAT_W3, OFS_CHEAT_W2,
        OFS_CHEAT_W1, OFS_CHEAT_W0, OFS_CHEAT_READY, OFS_SAVE_BSRAM, OFS_LOAD_BSRAM,
        OFS_SYS_TYPE, OFS_ASPECT
    };

    logic              clk = 1'b0;
    logic              resetn;
    bus_req_t          req;
    logic              mem_ready;
    logic [DATA_W-1:0] mem_rdata;
    cfg_t              cfg;
    logic              rom_loading;
    logic [7:0]        rom_do;
    logic              rom_do_valid;
    wb_out_t           wb;
    logic              wb_ack;
    logic              wb_stall;
    logic              wb_err;

    // Shadow registers and run bookkeeping
    cfg_t               shadow_cfg;
    logic [CHEAT_W-1:0] shadow_cheat;
    logic               shadow_ready;
    logic               shadow_loading;
    int                 cycle_cnt = 0;
    int                 last_issue;
    int unsigned        ack_delay = 0;
    int                 wb_beats = 0;
    wb_out_t            wb_seen;

    task automatic abort_run(input string reason);
        $display(">>> FAIL");
        $fatal(1, "%s", reason);
    endtask

    `include "iosys_periph_tb_tasks.svh"

    iosys_periph #(
        .TICKS_PER_MS (10)
    ) dut_i (
        .clk            (clk),
        .resetn         (resetn),
        .i_req          (req),
        .o_mem_ready    (mem_ready),
        .o_mem_rdata    (mem_rdata),
        .o_cfg          (cfg),
        .o_rom_loading  (rom_loading),
        .o_rom_do       (rom_do),
        .o_rom_do_valid (rom_do_valid),
        .o_wb           (wb),
        .i_wb_ack       (wb_ack),
        .i_wb_stall     (wb_stall),
        .i_wb_err       (wb_err)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run("timeout");
        end
    end

    // Wishbone beat monitor
    always @(negedge clk) begin
        if (wb.stb) begin
            wb_beats++;
            wb_seen = wb;
        end
    end

    // Slave picks a new ack delay at every strobe
    initial begin
        wb_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (wb.stb) begin
                ack_delay = $urandom_range(0, 6);
            end
            if (wb.cyc && !wb_ack && ack_delay == 0) begin
                wb_ack = 1'b1;
            end else begin
                wb_ack = 1'b0;
                if (wb.cyc && ack_delay != 0) begin
                    ack_delay--;
                end
            end
        end
    end

    initial begin
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] rdata;
        logic [DATA_W-1:0] first;
        int                issue0;
        int                beats0;
        wb_out_t           exp_wb;
        void'($urandom(32'he1a8_70d3));
        resetn = 1'b0;
        req = '0;
        wb_stall = 1'b0;
        wb_err = 1'b0;
        shadow_cfg = '0;
        shadow_cheat = '0;
        shadow_ready = 1'b0;
        shadow_loading = 1'b0;
        wait_cycles(2);
        resetn = 1'b1;
        compare_cfg("o_cfg after reset", cfg, '0);
        compare_word("flags after reset",
                     {27'd0, mem_ready, rom_loading, rom_do_valid, wb.cyc, wb.stb}, 32'd0);

        // Config registers, pending stays clear here
        for (int round = 0; round < 3; round++) begin
            for (int i = 0; i < 12; i++) begin
                wdata = $urandom();
                if (RW_OFS[i] == OFS_CHEAT_READY) begin
                    wdata[0] = 1'b0;
                end
                write_reg(REG_BASE + RW_OFS[i], wdata);
            end
            for (int i = 0; i < 12; i++) begin
                read_check(REG_BASE + RW_OFS[i]);
            end
            compare_cfg("o_cfg", cfg, shadow_cfg);
        end
        write_reg(REG_BASE + 32'h004, $urandom());
        write_reg(32'h0300_0080, $urandom());
        read_check(REG_BASE + 32'h004);
        read_check(32'h0300_0080);
        for (int i = 0; i < 12; i++) begin
            read_check(REG_BASE + RW_OFS[i]);
        end
        compare_cfg("o_cfg after unmapped writes", cfg, shadow_cfg);

        // ROM streaming, bus_access returns in the second valid cycle of byte 0
        write_reg(REG_BASE + OFS_ROM_CTRL, 32'd1);
        compare_word("o_rom_loading", {31'd0, rom_loading}, {31'd0, shadow_loading});
        wdata = $urandom();
        write_reg(REG_BASE + OFS_ROM_DATA, wdata);
        for (int i = 1; i < 4 * ROM_SLOT; i++) begin
            compare_word("o_rom_do_valid", {31'd0, rom_do_valid},
                         {31'd0, (i % ROM_SLOT) < ROM_BYTE_CYCLES});
            if (rom_do_valid) begin
                compare_byte("o_rom_do", rom_do, wdata[8 * (i / ROM_SLOT) +: 8]);
            end
            wait_cycles(1);
        end
        compare_word("o_rom_do_valid after word", {31'd0, rom_do_valid}, 32'd0);
        write_reg(REG_BASE + OFS_ROM_CTRL, 32'd5);
        compare_word("o_rom_loading", {31'd0, rom_loading}, {31'd0, shadow_loading});
        write_reg(REG_BASE + OFS_ROM_CTRL, 32'd0);
        compare_word("o_rom_loading", {31'd0, rom_loading}, {31'd0, shadow_loading});
        write_reg(REG_BASE + OFS_ROM_CTRL, 32'd5);
        compare_word("o_rom_loading", {31'd0, rom_loading}, {31'd0, shadow_loading});

        // Cheat upload
        for (int i = 0; i < 4; i++) begin
            write_reg(REG_BASE + OFS_CHEAT_W3 + 32'(i * 32'h20), $urandom());
        end
        write_reg(REG_BASE + OFS_CHEAT_EN, 32'd1);
        beats0 = wb_beats;
        write_reg(REG_BASE + OFS_CHEAT_READY, 32'd1);
        while (wb_beats == beats0) begin
            wait_cycles(1);
        end
        exp_wb = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, addr: WB_CHEAT_ADDR,
                   data: shadow_cheat, sel: 4'hF};
        compare_wb("o_wb", wb_seen, exp_wb);
        while (wb.cyc) begin
            wait_cycles(1);
        end
        shadow_ready = 1'b0;
        read_check(REG_BASE + OFS_CHEAT_READY);
        check_that(wb_beats == beats0 + 1, "more than one Wishbone beat per cheat block");

        // No cycle while cheats are disabled
        write_reg(REG_BASE + OFS_CHEAT_EN, 32'd0);
        beats0 = wb_beats;
        write_reg(REG_BASE + OFS_CHEAT_READY, 32'd1);
        wait_cycles(20);
        check_that(wb_beats == beats0 && !wb.cyc, "Wishbone cycle with cheats disabled");
        read_check(REG_BASE + OFS_CHEAT_READY);
        write_reg(REG_BASE + OFS_CHEAT_READY, 32'd0);

        // Counters
        bus_access(REG_BASE + OFS_CYCLES, 32'd0, 4'h0, first);
        issue0 = last_issue;
        wait_cycles($urandom_range(5, 40));
        bus_access(REG_BASE + OFS_CYCLES, 32'd0, 4'h0, rdata);
        compare_word("REG_CYCLES delta", rdata - first, 32'(last_issue - issue0));
        wait_cycles(100);
        bus_access(REG_BASE + OFS_TIME_MS, 32'd0, 4'h0, rdata);
        check_that(rdata >= 32'd10, "millisecond counter below 10 after 100 cycles");
        compare_cfg("o_cfg at end", cfg, shadow_cfg);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* iosys_periph.f */
+incdir+include
hdl/iosys_bus_pkg.sv
hdl/iosys_cfg_pkg.sv
hdl/reg_decode.sv
hdl/reg_bank.sv
hdl/rom_byte_streamer.sv
hdl/cheat_wb_master.sv
hdl/iosys_periph.sv
verif/iosys_periph_assertions.sv
verif/iosys_periph_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the iosys_periph testbench with Verilator.
# The simulator exits non-zero on $fatal, which fails this script.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --top-module iosys_periph_tb \
    -f iosys_periph.f \
    -Mdir obj_dir \
    -o iosys_periph_sim

./obj_dir/iosys_periph_sim
